// File: hdl/cl_event_decode.sv
/*
 * Event decoder for the cache-line port monitor
 * Maps channel strobes and type codes to record kinds and flags,
 * stamps each event cycle with a cycle count, drives in-flight pulses
 */
`timescale 1ns/1ps

module cl_event_decode import cl_mon_pkg::*; (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                trace_enable,
   input  logic                soft_reset,
   input  logic                marker_en,
   input  logic [MARKER_W-1:0] marker_value,
   input  logic                c0tx_valid,
   input  logic [TYPE_W-1:0]   c0tx_req_type,
   input  logic                c1tx_valid,
   input  logic [TYPE_W-1:0]   c1tx_req_type,
   input  logic                c2tx_mmio_rd_valid,
   input  logic                c0rx_rsp_valid,
   input  logic [TYPE_W-1:0]   c0rx_rsp_type,
   input  logic                c0rx_umsg_hint,
   input  logic                c1rx_rsp_valid,
   input  logic [TYPE_W-1:0]   c1rx_rsp_type,
   input  logic                mmio_wr_valid,
   input  logic                mmio_rd_valid,
   output logic                rec_valid,
   output logic [REC_W-1:0]    rec_data,
   output logic                rd_issue,
   output logic                rd_done,
   output logic                wr_issue,
   output logic                wr_done
);

   // Cycle counter and previous soft reset level
   logic [TS_W-1:0]     ts_cnt;
   logic                soft_reset_q;
   logic [KIND_W-1:0]   c0tx_kind;
   logic [KIND_W-1:0]   c1tx_kind;
   logic [KIND_W-1:0]   c0rx_kind;
   logic [KIND_W-1:0]   c1rx_kind;
   logic [KIND_W-1:0]   mmio_kind;
   logic                unknown;
   logic                rst_toggle;
   logic                any_event;
   logic [MARKER_W-1:0] marker_field;

   //////////////////////////////
   // Per-channel classification
   always_comb begin
      c0tx_kind = KIND_NONE;
      c1tx_kind = KIND_NONE;
      c0rx_kind = KIND_NONE;
      c1rx_kind = KIND_NONE;
      unknown   = 1'b0;
      // Read requests
      if (c0tx_valid) begin
         case (c0tx_req_type)
            REQ_RDLINE_S: c0tx_kind = C0TX_RD_S;
            REQ_RDLINE_I: c0tx_kind = C0TX_RD_I;
            default:      unknown = 1'b1;
         endcase
      end
      // Write requests and fences
      if (c1tx_valid) begin
         case (c1tx_req_type)
            REQ_WRLINE_I: c1tx_kind = C1TX_WR_I;
            REQ_WRLINE_M: c1tx_kind = C1TX_WR_M;
            REQ_WRFENCE:  c1tx_kind = C1TX_FENCE;
            default:      unknown = 1'b1;
         endcase
      end
      // Read responses and messages, hint input picks the message kind
      if (c0rx_rsp_valid) begin
         case (c0rx_rsp_type)
            RSP_RDLINE: c0rx_kind = C0RX_RD_RSP;
            RSP_UMSG:   c0rx_kind = c0rx_umsg_hint ? C0RX_HINT : C0RX_DATA;
            default:    unknown = 1'b1;
         endcase
      end
      // Write and fence responses
      if (c1rx_rsp_valid) begin
         case (c1rx_rsp_type)
            RSP_WRLINE:  c1rx_kind = C1RX_WR_RSP;
            RSP_WRFENCE: c1rx_kind = C1RX_FNC_RSP;
            default:     unknown = 1'b1;
         endcase
      end
   end

   // MMIO kind, 1 write, 2 read, 3 both
   assign mmio_kind    = {mmio_rd_valid, mmio_wr_valid};
   assign rst_toggle   = soft_reset ^ soft_reset_q;
   assign marker_field = marker_en ? marker_value : '0;

   // Any nonzero kind or flag
   assign any_event = |{c0tx_kind, c1tx_kind, c2tx_mmio_rd_valid, c0rx_kind,
                        c1rx_kind, mmio_kind, rst_toggle, unknown, marker_en};

   //////////////////////////////
   // Control state and pulses
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ts_cnt       <= '0;
         soft_reset_q <= 1'b0;
         rec_valid    <= 1'b0;
         rd_issue     <= 1'b0;
         rd_done      <= 1'b0;
         wr_issue     <= 1'b0;
         wr_done      <= 1'b0;
      end else begin
         ts_cnt       <= ts_cnt + 1'b1;
         soft_reset_q <= soft_reset;
         rec_valid    <= trace_enable & any_event;
         // In-flight pulses, fences excluded
         rd_issue     <= (c0tx_kind != KIND_NONE);
         rd_done      <= (c0rx_kind == C0RX_RD_RSP);
         wr_issue     <= (c1tx_kind == C1TX_WR_I) || (c1tx_kind == C1TX_WR_M);
         wr_done      <= (c1rx_kind == C1RX_WR_RSP);
      end
   end

   // Record payload, stamped with the count at the sampling edge
   always_ff @(posedge clk) begin
      rec_data <= {ts_cnt, c0tx_kind, c1tx_kind, c2tx_mmio_rd_valid, c0rx_kind,
                   c1rx_kind, mmio_kind, rst_toggle, unknown, marker_en, marker_field};
   end

endmodule

// File: hdl/cl_mon_pkg.sv
/*
 * Shared definitions for the cache-line port monitor
 * Request and response type codes, per-channel event kind codes,
 * trace record field widths, buffer depth and counter width
 */
package cl_mon_pkg;

   // Width of every request and response type field
   localparam int TYPE_W = 4;

   // Request codes, accelerator to memory
   localparam logic [TYPE_W-1:0] REQ_RDLINE_S = 4'd0;
   localparam logic [TYPE_W-1:0] REQ_RDLINE_I = 4'd1;
   localparam logic [TYPE_W-1:0] REQ_WRLINE_I = 4'd2;
   localparam logic [TYPE_W-1:0] REQ_WRLINE_M = 4'd3;
   localparam logic [TYPE_W-1:0] REQ_WRFENCE  = 4'd4;

   // Response codes, memory to accelerator
   localparam logic [TYPE_W-1:0] RSP_RDLINE  = 4'd0;
   localparam logic [TYPE_W-1:0] RSP_WRLINE  = 4'd1;
   localparam logic [TYPE_W-1:0] RSP_WRFENCE = 4'd2;
   localparam logic [TYPE_W-1:0] RSP_UMSG    = 4'd4;

   ////////////////////////////////
   // Kind fields, 0 is no event
   localparam int KIND_W = 2;
   localparam logic [KIND_W-1:0] KIND_NONE    = 2'd0;
   localparam logic [KIND_W-1:0] C0TX_RD_S    = 2'd1;
   localparam logic [KIND_W-1:0] C0TX_RD_I    = 2'd2;
   localparam logic [KIND_W-1:0] C1TX_WR_I    = 2'd1;
   localparam logic [KIND_W-1:0] C1TX_WR_M    = 2'd2;
   localparam logic [KIND_W-1:0] C1TX_FENCE   = 2'd3;
   localparam logic [KIND_W-1:0] C0RX_RD_RSP  = 2'd1;
   localparam logic [KIND_W-1:0] C0RX_HINT    = 2'd2;
   localparam logic [KIND_W-1:0] C0RX_DATA    = 2'd3;
   localparam logic [KIND_W-1:0] C1RX_WR_RSP  = 2'd1;
   localparam logic [KIND_W-1:0] C1RX_FNC_RSP = 2'd2;

   ////////////////////////////////
   // Record layout, timestamp at the top, marker value at the bottom
   localparam int MARKER_W = 8;
   localparam int TS_W     = 24;
   localparam int REC_W    = TS_W + 5*KIND_W + 4 + MARKER_W;

   // Trace buffer and counters
   localparam int TRACE_DEPTH = 16;
   localparam int PTR_W       = $clog2(TRACE_DEPTH);
   localparam int CNT_W       = 8;

endpackage

// File: hdl/cl_monitor_top.sv
/*
 * Cache-line port monitor top level
 * Decoder, trace buffer and in-flight counters
 */
`timescale 1ns/1ps

module cl_monitor_top import cl_mon_pkg::*; (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                c0tx_valid,
   input  logic [TYPE_W-1:0]   c0tx_req_type,
   input  logic                c1tx_valid,
   input  logic [TYPE_W-1:0]   c1tx_req_type,
   input  logic                c2tx_mmio_rd_valid,
   input  logic                c0rx_rsp_valid,
   input  logic [TYPE_W-1:0]   c0rx_rsp_type,
   input  logic                c0rx_umsg_hint,
   input  logic                c1rx_rsp_valid,
   input  logic [TYPE_W-1:0]   c1rx_rsp_type,
   input  logic                mmio_wr_valid,
   input  logic                mmio_rd_valid,
   input  logic                soft_reset,
   input  logic                trace_enable,
   input  logic                marker_en,
   input  logic [MARKER_W-1:0] marker_value,
   input  logic                trace_pop,
   output logic                trace_valid,
   output logic [REC_W-1:0]    trace_data,
   output logic [CNT_W-1:0]    trace_dropped,
   output logic [CNT_W-1:0]    rd_outstanding,
   output logic [CNT_W-1:0]    wr_outstanding
);

   // Decoder to buffer
   logic             rec_valid;
   logic [REC_W-1:0] rec_data;
   // Decoder to in-flight counters
   logic             rd_issue;
   logic             rd_done;
   logic             wr_issue;
   logic             wr_done;

   //////////////////////////////
   cl_event_decode u_decode (
      .clk, .arst_n, .trace_enable, .soft_reset, .marker_en, .marker_value,
      .c0tx_valid, .c0tx_req_type, .c1tx_valid, .c1tx_req_type,
      .c2tx_mmio_rd_valid, .c0rx_rsp_valid, .c0rx_rsp_type, .c0rx_umsg_hint,
      .c1rx_rsp_valid, .c1rx_rsp_type, .mmio_wr_valid, .mmio_rd_valid,
      .rec_valid, .rec_data, .rd_issue, .rd_done, .wr_issue, .wr_done
   );

   // Records drained by the reader
   cl_trace_fifo u_fifo (
      .clk, .arst_n, .rec_valid, .rec_data, .trace_pop,
      .trace_valid, .trace_data, .trace_dropped
   );

   // Reads and writes in flight
   cl_outstanding u_outstanding (
      .clk, .arst_n, .soft_reset, .rd_issue, .rd_done, .wr_issue, .wr_done,
      .rd_outstanding, .wr_outstanding
   );

endmodule

// File: hdl/cl_outstanding.sv
/*
 * In-flight transaction counters
 * Reads and write lines issued minus completed,
 * floored at zero, cleared while soft reset is high
 */
`timescale 1ns/1ps

module cl_outstanding import cl_mon_pkg::*; (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             soft_reset,
   input  logic             rd_issue,
   input  logic             rd_done,
   input  logic             wr_issue,
   input  logic             wr_done,
   output logic [CNT_W-1:0] rd_outstanding,
   output logic [CNT_W-1:0] wr_outstanding
);

   // Next value of one up/down count
   function automatic logic [CNT_W-1:0] next_cnt(
      input logic [CNT_W-1:0] cnt,
      input logic             inc,
      input logic             dec
   );
      logic [CNT_W-1:0] res;
      res = cnt;
      // Issue and completion together cancel
      if (inc && !dec && cnt != '1)
         res = cnt + 1'b1;
      // Completion at zero stays at zero
      else if (dec && !inc && cnt != '0)
         res = cnt - 1'b1;
      return res;
   endfunction

   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_outstanding <= '0;
         wr_outstanding <= '0;
      end else if (soft_reset) begin
         // Soft reset wins over any pulse
         rd_outstanding <= '0;
         wr_outstanding <= '0;
      end else begin
         rd_outstanding <= next_cnt(rd_outstanding, rd_issue, rd_done);
         wr_outstanding <= next_cnt(wr_outstanding, wr_issue, wr_done);
      end
   end

endmodule

// File: hdl/cl_trace_fifo.sv
/*
 * Trace record buffer
 * Circular store with pop readout, drop on full
 * and a saturating count of dropped records
 */
`timescale 1ns/1ps

module cl_trace_fifo import cl_mon_pkg::*; (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rec_valid,
   input  logic [REC_W-1:0] rec_data,
   input  logic             trace_pop,
   output logic             trace_valid,
   output logic [REC_W-1:0] trace_data,
   output logic [CNT_W-1:0] trace_dropped
);

   logic [REC_W-1:0] mem [TRACE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             full;
   logic             do_pop;
   logic             do_push;
   logic             do_drop;

   assign full        = (count == TRACE_DEPTH[PTR_W:0]);
   assign trace_valid = (count != '0);
   assign trace_data  = mem[rd_ptr];

   // Pop only when a record is shown
   assign do_pop  = trace_pop & trace_valid;
   // Full buffer still takes a record when one leaves in the same edge
   assign do_push = rec_valid & (~full | do_pop);
   assign do_drop = rec_valid & full & ~do_pop;

   //////////////////////////////
   // Pointers, count, drop counter
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         trace_dropped <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
         // Saturate at all ones
         if (do_drop && trace_dropped != '1)
            trace_dropped <= trace_dropped + 1'b1;
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= rec_data;
   end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the cache-line monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module cl_monitor_tb \
   -f tb.f -o Vcl_monitor_tb
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/Vcl_monitor_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides the result
if grep -q "test failed" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "test passed" "$LOG"; then
   echo "Simulation ended without a pass"
   exit 1
fi

echo "Simulation passed"
exit 0

// File: tb.f
hdl/cl_mon_pkg.sv
hdl/cl_event_decode.sv
hdl/cl_trace_fifo.sv
hdl/cl_outstanding.sv
hdl/cl_monitor_top.sv
test/cl_monitor_chk.sv
test/cl_monitor_tb.sv

// File: test/cl_monitor_chk.sv
/*
 * Assertions bound to the monitor top level
 * Empty buffer after reset, drop count never falls,
 * in-flight counts frozen under a held soft reset
 */
`timescale 1ns/1ps

module cl_monitor_chk import cl_mon_pkg::*; (
   input logic             clk,
   input logic             arst_n,
   input logic             soft_reset,
   input logic             trace_valid,
   input logic [CNT_W-1:0] trace_dropped,
   input logic [CNT_W-1:0] rd_outstanding,
   input logic [CNT_W-1:0] wr_outstanding
);

   // First edge out of reset sees no record
   empty_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !trace_valid)
      else $error("trace_valid high in the cycle after reset");

   // Saturating count only rises
   drop_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
      trace_dropped >= $past(trace_dropped))
      else $error("trace_dropped decreased");

   // Soft reset seen at two edges leaves both counts cleared and still
   counts_frozen: assert property (@(posedge clk) disable iff (!arst_n)
      ($past(soft_reset) && $past(soft_reset, 2)) |->
         ($stable(rd_outstanding) && $stable(wr_outstanding)))
      else $error("outstanding count changed under soft reset");

endmodule

bind cl_monitor_top cl_monitor_chk u_chk (.*);

// File: test/cl_monitor_tb.sv
/*
 * Testbench for the cache-line port monitor
 * Directed event table with a reference model and record readout,
 * random overflow phase, drop count and in-flight count checks
 */
`timescale 1ns/1ps

module cl_monitor_tb import cl_mon_pkg::*; ();

   localparam int N_ROWS   = 21;
   localparam int N_RAND   = 300;
   localparam int WAIT_MAX = 20;

   // One cycle of stimulus, msb first
   //   c0tx {valid, type}, c1tx {valid, type}, c0rx {valid, hint, type}, c1rx {valid, type}
   //   ctl {c2tx, mmio wr, mmio rd, soft reset, trace enable, marker en}, marker value
   //   expected kinds {c0tx, c1tx, c0rx, c1rx, unknown}
   typedef struct packed {
      logic [4:0] c0tx;
      logic [4:0] c1tx;
      logic [5:0] c0rx;
      logic [4:0] c1rx;
      logic [5:0] ctl;
      logic [7:0] mk;
      logic [8:0] kinds;
   } row_t;

   logic                clk;
   logic                arst_n;
   logic                c0tx_valid, c1tx_valid, c2tx_mmio_rd_valid;
   logic [TYPE_W-1:0]   c0tx_req_type, c1tx_req_type, c0rx_rsp_type, c1rx_rsp_type;
   logic                c0rx_rsp_valid, c0rx_umsg_hint, c1rx_rsp_valid;
   logic                mmio_wr_valid, mmio_rd_valid;
   logic                soft_reset, trace_enable, marker_en, trace_pop;
   logic [MARKER_W-1:0] marker_value;
   logic                trace_valid;
   logic [REC_W-1:0]    trace_data;
   logic [CNT_W-1:0]    trace_dropped, rd_outstanding, wr_outstanding;

   // Reference model state
   row_t                tbl [N_ROWS];
   logic [REC_W-1:0]    exp_q [$];
   logic [TS_W-1:0]     edge_cnt;
   logic                prev_sr;
   logic [CNT_W-1:0]    rd_exp, wr_exp, drop_exp;
   logic [31:0]         seed;

   cl_monitor_top dut (.*);

   always #50 clk = ~clk;

   // Index of the next sampling edge, seen 1 ns after an edge
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         edge_cnt <= '0;
      else
         edge_cnt <= edge_cnt + 1'b1;
   end

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   //////////////////////////////
   // Decoding rules, {c0tx, c1tx, c0rx, c1rx, unknown}
   function automatic logic [8:0] decode_kinds(input row_t r);
      logic [1:0] k0, k1, k2, k3;
      logic       unk;
      k0  = 2'd0;
      k1  = 2'd0;
      k2  = 2'd0;
      k3  = 2'd0;
      unk = 1'b0;
      if (r.c0tx[4]) begin
         if (r.c0tx[3:0] == REQ_RDLINE_S) k0 = 2'd1;
         else if (r.c0tx[3:0] == REQ_RDLINE_I) k0 = 2'd2;
         else unk = 1'b1;
      end
      if (r.c1tx[4]) begin
         if (r.c1tx[3:0] == REQ_WRLINE_I) k1 = 2'd1;
         else if (r.c1tx[3:0] == REQ_WRLINE_M) k1 = 2'd2;
         else if (r.c1tx[3:0] == REQ_WRFENCE) k1 = 2'd3;
         else unk = 1'b1;
      end
      // Hint bit picks hint or data for a message
      if (r.c0rx[5]) begin
         if (r.c0rx[3:0] == RSP_RDLINE) k2 = 2'd1;
         else if (r.c0rx[3:0] == RSP_UMSG) k2 = r.c0rx[4] ? 2'd2 : 2'd3;
         else unk = 1'b1;
      end
      if (r.c1rx[4]) begin
         if (r.c1rx[3:0] == RSP_WRLINE) k3 = 2'd1;
         else if (r.c1rx[3:0] == RSP_WRFENCE) k3 = 2'd2;
         else unk = 1'b1;
      end
      return {k0, k1, k2, k3, unk};
   endfunction

   // Up/down with floor at 0 and cap at all ones
   function automatic logic [CNT_W-1:0] step_cnt(input logic [CNT_W-1:0] c, input logic up,
                                                 input logic down);
      if (up && !down && c != 8'hff)
         return c + 1'b1;
      if (down && !up && c != 8'h00)
         return c - 1'b1;
      return c;
   endfunction

   // Holds soft reset, trace on, no events
   function automatic row_t idle_row();
      row_t x;
      x     = '0;
      x.ctl = {3'b000, prev_sr, 2'b10};
      return x;
   endfunction

   // Traffic with a marker in every cycle, soft reset off
   function automatic row_t random_row(input logic [31:0] r);
      row_t x;
      x.c0tx  = {r[31], 1'b0, r[30:28]};
      x.c1tx  = {r[27], 1'b0, r[26:24]};
      x.c0rx  = {r[23], r[22], 1'b0, r[21:19]};
      x.c1rx  = {r[18], 1'b0, r[17:15]};
      x.ctl   = {r[14:12], 3'b011};
      x.mk    = r[11:4];
      x.kinds = '0;
      // Kinds from the decoding rules
      x.kinds = decode_kinds(x);
      return x;
   endfunction

   //////////////////////////////
   // Expected record, buffer occupancy and counts for one cycle
   task automatic model_row(input row_t r);
      logic [8:0]       k;
      logic             tgl;
      logic [REC_W-1:0] rec;
      k       = r.kinds;
      tgl     = r.ctl[2] ^ prev_sr;
      prev_sr = r.ctl[2];
      rec = {edge_cnt, k[8:7], k[6:5], r.ctl[5], k[4:3], k[2:1], r.ctl[3], r.ctl[4],
             tgl, k[0], r.ctl[0], r.ctl[0] ? r.mk : 8'h00};
      if (r.ctl[1] && |rec[REC_W-TS_W-1:0]) begin
         if (exp_q.size() < TRACE_DEPTH)
            exp_q.push_back(rec);
         else if (drop_exp != 8'hff)
            drop_exp = drop_exp + 1'b1;
      end
      // Held soft reset clears across the row and its idle cycle
      if (r.ctl[2]) begin
         rd_exp = '0;
         wr_exp = '0;
      end else begin
         rd_exp = step_cnt(rd_exp, k[8:7] != 2'd0, k[4:3] == 2'd1);
         wr_exp = step_cnt(wr_exp, k[6:5] == 2'd1 || k[6:5] == 2'd2, k[2:1] == 2'd1);
      end
   endtask

   task automatic set_inputs(input row_t r);
      c0tx_valid         = r.c0tx[4];
      c0tx_req_type      = r.c0tx[3:0];
      c1tx_valid         = r.c1tx[4];
      c1tx_req_type      = r.c1tx[3:0];
      c0rx_rsp_valid     = r.c0rx[5];
      c0rx_umsg_hint     = r.c0rx[4];
      c0rx_rsp_type      = r.c0rx[3:0];
      c1rx_rsp_valid     = r.c1rx[4];
      c1rx_rsp_type      = r.c1rx[3:0];
      c2tx_mmio_rd_valid = r.ctl[5];
      mmio_wr_valid      = r.ctl[4];
      mmio_rd_valid      = r.ctl[3];
      soft_reset         = r.ctl[2];
      trace_enable       = r.ctl[1];
      marker_en          = r.ctl[0];
      marker_value       = r.mk;
   endtask

   task automatic drive_row(input row_t r);
      set_inputs(r);
      model_row(r);
   endtask

   task automatic abort();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, act, exp);
         abort();
      end
   endtask

   task automatic check_counts();
      check("rd_outstanding", 32'(rd_outstanding), 32'(rd_exp));
      check("wr_outstanding", 32'(wr_outstanding), 32'(wr_exp));
      check("trace_dropped", 32'(trace_dropped), 32'(drop_exp));
   endtask

   //////////////////////////////
   // Wait for a record, compare field by field, pop it
   task automatic pop_compare(input logic [REC_W-1:0] e);
      int n;
      n = 0;
      while (!trace_valid) begin
         if (n == WAIT_MAX) begin
            $display("No trace record became visible within %0d cycles", WAIT_MAX);
            abort();
         end
         @(posedge clk);
         #1;
         n++;
      end
      check("trace_data timestamp", 32'(trace_data[45:22]), 32'(e[45:22]));
      check("trace_data c0tx kind", 32'(trace_data[21:20]), 32'(e[21:20]));
      check("trace_data c1tx kind", 32'(trace_data[19:18]), 32'(e[19:18]));
      check("trace_data c2tx flag", 32'(trace_data[17]), 32'(e[17]));
      check("trace_data c0rx kind", 32'(trace_data[16:15]), 32'(e[16:15]));
      check("trace_data c1rx kind", 32'(trace_data[14:13]), 32'(e[14:13]));
      check("trace_data mmio kind", 32'(trace_data[12:11]), 32'(e[12:11]));
      check("trace_data reset toggle", 32'(trace_data[10]), 32'(e[10]));
      check("trace_data unknown", 32'(trace_data[9]), 32'(e[9]));
      check("trace_data marker valid", 32'(trace_data[8]), 32'(e[8]));
      check("trace_data marker value", 32'(trace_data[7:0]), 32'(e[7:0]));
      trace_pop = 1'b1;
      @(posedge clk);
      #1;
      trace_pop = 1'b0;
   endtask

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      trace_pop = 1'b0;
      set_inputs('0);
      prev_sr   = 1'b0;
      rd_exp    = '0;
      wr_exp    = '0;
      drop_exp  = '0;
      seed      = 32'd9;

      // Every known code per channel
      tbl[0]  = {5'h10, 5'h00, 6'h00, 5'h00, 6'b000010, 8'h00, 9'b01_00_00_00_0};
      tbl[1]  = {5'h11, 5'h00, 6'h00, 5'h00, 6'b000010, 8'h00, 9'b10_00_00_00_0};
      tbl[2]  = {5'h00, 5'h12, 6'h00, 5'h00, 6'b000010, 8'h00, 9'b00_01_00_00_0};
      tbl[3]  = {5'h00, 5'h13, 6'h00, 5'h00, 6'b000010, 8'h00, 9'b00_10_00_00_0};
      tbl[4]  = {5'h00, 5'h14, 6'h00, 5'h00, 6'b000010, 8'h00, 9'b00_11_00_00_0};
      tbl[5]  = {5'h00, 5'h00, 6'h20, 5'h00, 6'b000010, 8'h00, 9'b00_00_01_00_0};
      tbl[6]  = {5'h00, 5'h00, 6'h34, 5'h00, 6'b000010, 8'h00, 9'b00_00_10_00_0};
      tbl[7]  = {5'h00, 5'h00, 6'h24, 5'h00, 6'b000010, 8'h00, 9'b00_00_11_00_0};
      tbl[8]  = {5'h00, 5'h00, 6'h00, 5'h11, 6'b000010, 8'h00, 9'b00_00_00_01_0};
      tbl[9]  = {5'h00, 5'h00, 6'h00, 5'h12, 6'b000010, 8'h00, 9'b00_00_00_10_0};
      tbl[10] = {5'h00, 5'h00, 6'h00, 5'h00, 6'b100010, 8'h00, 9'b00_00_00_00_0};
      tbl[11] = {5'h00, 5'h00, 6'h00, 5'h00, 6'b011010, 8'h00, 9'b00_00_00_00_0};
      // Unknown codes, marker, soft reset on and off
      tbl[12] = {5'h17, 5'h1f, 6'h23, 5'h15, 6'b000010, 8'h00, 9'b00_00_00_00_1};
      tbl[13] = {5'h00, 5'h00, 6'h00, 5'h00, 6'b000011, 8'ha5, 9'b00_00_00_00_0};
      tbl[14] = {5'h10, 5'h00, 6'h00, 5'h00, 6'b000110, 8'h00, 9'b01_00_00_00_0};
      tbl[15] = {5'h00, 5'h00, 6'h00, 5'h00, 6'b000010, 8'h00, 9'b00_00_00_00_0};
      // Trace off, completions at zero, quiet cycle, issue with completion
      tbl[16] = {5'h10, 5'h12, 6'h00, 5'h00, 6'b000000, 8'h00, 9'b01_01_00_00_0};
      tbl[17] = {5'h00, 5'h00, 6'h20, 5'h11, 6'b000000, 8'h00, 9'b00_00_01_01_0};
      tbl[18] = {5'h00, 5'h00, 6'h20, 5'h11, 6'b000010, 8'h00, 9'b00_00_01_01_0};
      tbl[19] = {5'h00, 5'h00, 6'h00, 5'h00, 6'b000010, 8'h00, 9'b00_00_00_00_0};
      tbl[20] = {5'h11, 5'h13, 6'h20, 5'h11, 6'b000010, 8'h00, 9'b10_10_01_01_0};

      repeat (16) @(posedge clk);
      #20 arst_n = 1'b1;
      @(posedge clk);
      #1;
      check("trace_valid", 32'(trace_valid), 32'd0);
      check_counts();

      //////////////////////////////
      // Directed rows, each drained before the next
      for (int i = 0; i < N_ROWS; i++) begin
         drive_row(tbl[i]);
         @(posedge clk);
         #1;
         drive_row(idle_row());
         @(posedge clk);
         #1;
         check_counts();
         while (exp_q.size() > 0)
            pop_compare(exp_q.pop_front());
         check("trace_valid", 32'(trace_valid), 32'd0);
      end

      //////////////////////////////
      // Overflow, no pops until the traffic stops
      for (int i = 0; i < N_RAND; i++) begin
         seed = lcg(seed);
         drive_row(random_row(seed));
         @(posedge clk);
         #1;
      end
      drive_row(idle_row());
      @(posedge clk);
      #1;
      check_counts();
      while (exp_q.size() > 0)
         pop_compare(exp_q.pop_front());
      check("trace_valid", 32'(trace_valid), 32'd0);

      $display("test passed");
      $finish;
   end

endmodule
